// File: logic/fp_pkg.sv
package fp_pkg;

    // single precision word layout
    localparam int FLOAT_WIDTH = 32;
    localparam int EXP_WIDTH = 8;
    localparam int MANT_WIDTH = 23;
    localparam int EXP_BIAS = 127;

    // byte address width of the register map
    localparam int ADDR_WIDTH = 5;

    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [MANT_WIDTH-1:0] mant;
    } float_fields_t;

    // raw view for the bus side, field view for the arithmetic
    typedef union packed {
        logic [FLOAT_WIDTH-1:0] raw;
        float_fields_t          f;
    } float_word_u;

    // bit 0 of the control word
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_MUL = 1'b1
    } fp_opcode_e;

    // register offsets
    localparam logic [ADDR_WIDTH-1:0] REG_A = 5'h00;
    localparam logic [ADDR_WIDTH-1:0] REG_B = 5'h04;
    localparam logic [ADDR_WIDTH-1:0] REG_CTRL = 5'h08;
    localparam logic [ADDR_WIDTH-1:0] REG_RESULT = 5'h0C;
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 5'h10;

endpackage

// File: logic/fp_op_if.sv
`timescale 1ns/1ns

// one operation request and its result between requester and arithmetic unit
interface fp_op_if;

    // one-cycle start pulse, only while the unit is idle
    logic req;
    // operands, stable during the req cycle
    fp_pkg::float_word_u a;
    fp_pkg::float_word_u b;
    // valid only in the ack cycle, no back-pressure
    fp_pkg::float_word_u result;
    logic ack;

    modport requester (
        output req, a, b,
        input  result, ack
    );

    modport unit (
        input  req, a, b,
        output result, ack
    );

endinterface

// File: logic/fp_add.sv
`timescale 1ns/1ns

module fp_add (
    input  logic  clk,
    input  logic  rst,
    fp_op_if.unit op
);

    localparam int MW = fp_pkg::MANT_WIDTH;
    localparam int EW = fp_pkg::EXP_WIDTH;
    // wide enough for a left shift of up to MW places
    localparam int SW = $clog2(MW + 1);

    typedef enum logic [1:0] {
        IDLE,
        ALIGN,
        ADDSUB,
        NORM
    } state_e;

    state_e state;
    state_e n_state;

    // captured operands
    fp_pkg::float_word_u a_q;
    fp_pkg::float_word_u b_q;
    fp_pkg::float_word_u n_a_q;
    fp_pkg::float_word_u n_b_q;

    // aligned mantissas laid out as [overflow][hidden one][stored bits]
    logic [MW+1:0] a_mant;
    logic [MW+1:0] b_mant;
    logic [MW+1:0] n_a_mant;
    logic [MW+1:0] n_b_mant;
    logic          a_sign;
    logic          b_sign;
    logic          n_a_sign;
    logic          n_b_sign;

    // working sum, exponent is the larger input exponent until normalized
    logic [EW-1:0] sum_exp;
    logic [EW-1:0] n_sum_exp;
    logic [MW+1:0] sum_mant;
    logic [MW+1:0] n_sum_mant;
    logic          sum_sign;
    logic          n_sum_sign;

    // combinational temporaries
    logic [EW-1:0] exp_diff;
    logic [MW+1:0] norm_mant;
    logic [EW-1:0] norm_exp;
    logic [SW-1:0] lead_shift;

    fp_pkg::float_word_u n_result;
    logic                n_ack;

    always_comb begin
        n_state = state;
        n_a_q = a_q;
        n_b_q = b_q;
        n_a_mant = a_mant;
        n_b_mant = b_mant;
        n_a_sign = a_sign;
        n_b_sign = b_sign;
        n_sum_exp = sum_exp;
        n_sum_mant = sum_mant;
        n_sum_sign = sum_sign;
        exp_diff = '0;
        norm_mant = sum_mant;
        norm_exp = sum_exp;
        lead_shift = '0;
        n_result = '0;
        n_ack = 1'b0;

        case (state)
            IDLE: begin
                if (op.req) begin
                    n_a_q = op.a;
                    n_b_q = op.b;
                    n_state = ALIGN;
                end
            end
            ALIGN: begin
                n_a_sign = a_q.f.sign;
                n_b_sign = b_q.f.sign;
                // hidden one always present, exponent 0 is just a small normal
                n_a_mant = {2'b01, a_q.f.mant};
                n_b_mant = {2'b01, b_q.f.mant};
                // keep the larger exponent, shift the other mantissa right
                // bits shifted out are simply lost
                if (a_q.f.exp > b_q.f.exp) begin
                    n_sum_exp = a_q.f.exp;
                    exp_diff = a_q.f.exp - b_q.f.exp;
                    n_b_mant = n_b_mant >> exp_diff;
                end else begin
                    n_sum_exp = b_q.f.exp;
                    exp_diff = b_q.f.exp - a_q.f.exp;
                    n_a_mant = n_a_mant >> exp_diff;
                end
                n_state = ADDSUB;
            end
            ADDSUB: begin
                if (a_sign != b_sign) begin
                    // subtract smaller magnitude, sign follows the larger one
                    if (a_mant > b_mant) begin
                        n_sum_mant = a_mant - b_mant;
                        n_sum_sign = a_sign;
                    end else begin
                        n_sum_mant = b_mant - a_mant;
                        n_sum_sign = b_sign;
                    end
                end else begin
                    n_sum_mant = a_mant + b_mant;
                    n_sum_sign = a_sign;
                end
                n_state = NORM;
            end
            NORM: begin
                // carry out of the add, one step right
                if (norm_mant[MW+1]) begin
                    norm_mant = norm_mant >> 1;
                    norm_exp = norm_exp + 1'b1;
                end
                if (norm_mant == '0) begin
                    // exact cancellation gives +0
                    n_result = '0;
                end else begin
                    // highest set bit wins, so the last hit in the loop counts
                    for (int i = 0; i <= MW; i++) begin
                        if (norm_mant[i]) begin
                            lead_shift = SW'(MW - i);
                        end
                    end
                    norm_mant = norm_mant << lead_shift;
                    norm_exp = norm_exp - EW'(lead_shift);
                    n_result.f.sign = sum_sign;
                    n_result.f.exp = norm_exp;
                    n_result.f.mant = norm_mant[MW-1:0];
                end
                n_ack = 1'b1;
                n_state = IDLE;
            end
            default: begin
                n_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            op.ack <= 1'b0;
        end else begin
            state <= n_state;
            op.ack <= n_ack;
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        a_q <= n_a_q;
        b_q <= n_b_q;
        a_mant <= n_a_mant;
        b_mant <= n_b_mant;
        a_sign <= n_a_sign;
        b_sign <= n_b_sign;
        sum_exp <= n_sum_exp;
        sum_mant <= n_sum_mant;
        sum_sign <= n_sum_sign;
        op.result <= n_result;
    end

endmodule

// File: logic/fp_mul.sv
`timescale 1ns/1ns

module fp_mul (
    input  logic  clk,
    input  logic  rst,
    fp_op_if.unit op
);

    localparam int MW = fp_pkg::MANT_WIDTH;
    localparam int EW = fp_pkg::EXP_WIDTH;
    // product of two mantissas with hidden ones
    localparam int PW = 2 * (MW + 1);

    // pipeline valid flags
    logic cap_valid;
    logic s1_valid;

    // captured operands
    fp_pkg::float_word_u a_q;
    fp_pkg::float_word_u b_q;

    // stage one results
    logic          s1_sign;
    logic [EW-1:0] s1_exp;
    logic [PW-1:0] s1_prod;

    // combinational
    logic [PW-1:0]       prod;
    logic [EW-1:0]       biased_exp;
    fp_pkg::float_word_u n_result;

    always_comb begin
        prod = {1'b1, a_q.f.mant} * {1'b1, b_q.f.mant};
        // exponents wrap, no overflow handling
        biased_exp = a_q.f.exp + b_q.f.exp - EW'(fp_pkg::EXP_BIAS);
    end

    // product lies in [1,4), so at most one right step
    always_comb begin
        n_result.f.sign = s1_sign;
        if (s1_prod[PW-1]) begin
            n_result.f.exp = s1_exp + 1'b1;
            n_result.f.mant = s1_prod[PW-2:MW+1];
        end else begin
            n_result.f.exp = s1_exp;
            n_result.f.mant = s1_prod[PW-3:MW];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cap_valid <= 1'b0;
            s1_valid <= 1'b0;
            op.ack <= 1'b0;
        end else begin
            cap_valid <= op.req;
            s1_valid <= cap_valid;
            // one-cycle ack with the result
            op.ack <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op.req) begin
            a_q <= op.a;
            b_q <= op.b;
        end
        if (cap_valid) begin
            s1_sign <= a_q.f.sign ^ b_q.f.sign;
            s1_exp <= biased_exp;
            s1_prod <= prod;
        end
        // low bits of the product are dropped, truncation only
        if (s1_valid) begin
            op.result <= n_result;
        end
    end

endmodule

// File: logic/fp_axil_regs.sv
`timescale 1ns/1ns

module fp_axil_regs (
    input  logic                           clk,
    input  logic                           rst,
    // write address and data
    input  logic [fp_pkg::ADDR_WIDTH-1:0]  awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [fp_pkg::FLOAT_WIDTH-1:0] wdata,
    input  logic                           wvalid,
    output logic                           wready,
    // write response
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    // read address and data
    input  logic [fp_pkg::ADDR_WIDTH-1:0]  araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [fp_pkg::FLOAT_WIDTH-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    // arithmetic units
    fp_op_if.requester                     add_if,
    fp_op_if.requester                     mul_if
);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    fp_pkg::float_word_u op_a;
    fp_pkg::float_word_u op_b;
    fp_pkg::float_word_u result;
    fp_pkg::fp_opcode_e  ctrl_op;
    logic                busy;
    logic                done;

    logic                           wr_offer;
    logic                           wr_en;
    logic [fp_pkg::FLOAT_WIDTH-1:0] rd_data;

    function automatic logic reg_mapped(input logic [fp_pkg::ADDR_WIDTH-1:0] addr);
        return addr inside {fp_pkg::REG_A, fp_pkg::REG_B, fp_pkg::REG_CTRL,
                            fp_pkg::REG_RESULT, fp_pkg::REG_STATUS};
    endfunction

    // both units see the same operand registers
    assign add_if.a = op_a;
    assign add_if.b = op_b;
    assign mul_if.a = op_a;
    assign mul_if.b = op_b;

    // address and data together, no response outstanding
    assign wr_offer = awvalid && wvalid && !awready && !bvalid;
    assign wr_en = awready && awvalid && wvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= RESP_OKAY;
            op_a <= '0;
            op_b <= '0;
            ctrl_op <= fp_pkg::OP_ADD;
            result <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            add_if.req <= 1'b0;
            mul_if.req <= 1'b0;
        end else begin
            // req lines are single pulses
            add_if.req <= 1'b0;
            mul_if.req <= 1'b0;
            awready <= wr_offer;
            wready <= wr_offer;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp <= reg_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
                case (awaddr)
                    fp_pkg::REG_A: op_a.raw <= wdata;
                    fp_pkg::REG_B: op_b.raw <= wdata;
                    fp_pkg::REG_CTRL: begin
                        // start while busy is acknowledged but dropped
                        if (!busy) begin
                            ctrl_op <= fp_pkg::fp_opcode_e'(wdata[0]);
                            busy <= 1'b1;
                            done <= 1'b0;
                            if (fp_pkg::fp_opcode_e'(wdata[0]) == fp_pkg::OP_MUL) begin
                                mul_if.req <= 1'b1;
                            end else begin
                                add_if.req <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
            // only the started unit can answer
            if (add_if.ack) begin
                result <= add_if.result;
                busy <= 1'b0;
                done <= 1'b1;
            end else if (mul_if.ack) begin
                result <= mul_if.result;
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // read mux, unmapped offsets read as zero
    always_comb begin
        rd_data = '0;
        case (araddr)
            fp_pkg::REG_A: rd_data = op_a.raw;
            fp_pkg::REG_B: rd_data = op_b.raw;
            fp_pkg::REG_CTRL: rd_data = {{(fp_pkg::FLOAT_WIDTH - 1){1'b0}}, ctrl_op};
            fp_pkg::REG_RESULT: rd_data = result.raw;
            fp_pkg::REG_STATUS: rd_data = {{(fp_pkg::FLOAT_WIDTH - 2){1'b0}}, done, busy};
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rdata <= '0;
            rresp <= RESP_OKAY;
        end else begin
            // single pulse, only with no read data pending
            arready <= arvalid && !arready && !rvalid;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arready && arvalid) begin
                rvalid <= 1'b1;
                rdata <= rd_data;
                rresp <= reg_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
            end
        end
    end

endmodule

// File: logic/fp_unit_top.sv
`timescale 1ns/1ns

module fp_unit_top (
    input  logic                           clk,
    input  logic                           rst,
    // axi4-lite write channels
    input  logic [fp_pkg::ADDR_WIDTH-1:0]  awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [fp_pkg::FLOAT_WIDTH-1:0] wdata,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    // axi4-lite read channels
    input  logic [fp_pkg::ADDR_WIDTH-1:0]  araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [fp_pkg::FLOAT_WIDTH-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready
);

    // one request path per arithmetic unit
    fp_op_if add_if ();
    fp_op_if mul_if ();

    fp_axil_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .add_if  (add_if),
        .mul_if  (mul_if)
    );

    // three steps after req
    fp_add u_add (
        .clk (clk),
        .rst (rst),
        .op  (add_if)
    );

    // two steps after req
    fp_mul u_mul (
        .clk (clk),
        .rst (rst),
        .op  (mul_if)
    );

endmodule

// File: test/fp_model.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// reference sum: hidden one always set, truncating alignment, no rounding
function automatic logic [31:0] expected_sum(input logic [31:0] a, input logic [31:0] b);
    fp_pkg::float_word_u ua;
    fp_pkg::float_word_u ub;
    logic [24:0]         ma;
    logic [24:0]         mb;
    logic [24:0]         m;
    logic [7:0]          e;
    logic                s;
    ua.raw = a;
    ub.raw = b;
    ma = {2'b01, ua.f.mant};
    mb = {2'b01, ub.f.mant};
    // the operand with the smaller exponent loses its low bits
    if (ua.f.exp > ub.f.exp) begin
        e = ua.f.exp;
        mb = mb >> (int'(ua.f.exp) - int'(ub.f.exp));
    end else begin
        e = ub.f.exp;
        ma = ma >> (int'(ub.f.exp) - int'(ua.f.exp));
    end
    if (ua.f.sign == ub.f.sign) begin
        m = ma + mb;
        s = ua.f.sign;
    end else if (ma > mb) begin
        m = ma - mb;
        s = ua.f.sign;
    end else begin
        m = mb - ma;
        s = ub.f.sign;
    end
    // carry out takes one step right
    if (m[24]) begin
        m = m >> 1;
        e = e + 8'd1;
    end
    if (m == 25'd0) begin
        return 32'd0;
    end
    // walk the leading one up to the hidden position
    while (!m[23]) begin
        m = m << 1;
        e = e - 8'd1;
    end
    return {s, e, m[22:0]};
endfunction

// reference product, exponent wraps in 8 bits, low product bits dropped
function automatic logic [31:0] expected_product(input logic [31:0] a, input logic [31:0] b);
    fp_pkg::float_word_u ua;
    fp_pkg::float_word_u ub;
    logic [47:0]         p;
    logic [7:0]          e;
    ua.raw = a;
    ub.raw = b;
    p = 48'({1'b1, ua.f.mant}) * 48'({1'b1, ub.f.mant});
    e = ua.f.exp + ub.f.exp - 8'(fp_pkg::EXP_BIAS);
    if (p[47]) begin
        return {ua.f.sign ^ ub.f.sign, e + 8'd1, p[46:24]};
    end
    return {ua.f.sign ^ ub.f.sign, e, p[45:23]};
endfunction

`endif

// File: test/tb_fp_unit.sv
`timescale 1ns/1ns

module tb_fp_unit;

    // about 220 operations at ~40 cycles each plus margin
    localparam int CYCLE_LIMIT = 20000;
    localparam logic [1:0] OKAY = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        clk;
    logic        rst;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    integer seed;
    int     cycles;
    int     checks;
    int     errors;
    int     test_errors;

    `include "fp_model.svh"

    fp_unit_top DUT (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit that catches a stuck handshake
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error %0s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        step_cycle();
        while (!awready) step_cycle();
        // wready pulses together with awready
        check_value("wready", 32'h1, 32'(wready));
        // address and data taken on this edge
        step_cycle();
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) step_cycle();
        resp = bresp;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr = addr;
        arvalid = 1'b1;
        step_cycle();
        while (!arready) step_cycle();
        step_cycle();
        arvalid = 1'b0;
        while (!rvalid) step_cycle();
        data = rdata;
        resp = rresp;
    endtask

    // load operands, start, poll for done, fetch the result
    task automatic run_operation(input fp_pkg::fp_opcode_e op, input logic [31:0] a,
                                 input logic [31:0] b, output logic [31:0] result);
        logic [1:0]  resp;
        logic [31:0] status;
        write_reg(fp_pkg::REG_A, a, resp);
        write_reg(fp_pkg::REG_B, b, resp);
        write_reg(fp_pkg::REG_CTRL, 32'(op), resp);
        check_value("bresp", 32'(OKAY), 32'(resp));
        status = '0;
        while (!status[1]) read_reg(fp_pkg::REG_STATUS, status, resp);
        read_reg(fp_pkg::REG_RESULT, result, resp);
    endtask

    function automatic logic [31:0] random_operand();
        logic [31:0] r;
        logic [31:0] m;
        r = $random(seed);
        m = $random(seed);
        // exponent kept in 64..191
        return {r[7], 8'd64 + {1'b0, r[6:0]}, m[22:0]};
    endfunction

    task automatic finish_test(input string name);
        $display("test %0s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic [1:0]  resp;
        seed = 30181;
        checks = 0;
        errors = 0;
        test_errors = 0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // responses taken as soon as offered
        bready = 1'b1;
        rready = 1'b1;

        read_reg(fp_pkg::REG_STATUS, data, resp);
        check_value("status", 32'h0, data);
        read_reg(fp_pkg::REG_RESULT, data, resp);
        check_value("result", 32'h0, data);
        check_value("rresp", 32'(OKAY), 32'(resp));
        finish_test("reset_values");

        a = random_operand();
        b = random_operand();
        write_reg(fp_pkg::REG_A, a, resp);
        check_value("bresp", 32'(OKAY), 32'(resp));
        write_reg(fp_pkg::REG_B, b, resp);
        check_value("bresp", 32'(OKAY), 32'(resp));
        read_reg(fp_pkg::REG_A, data, resp);
        check_value("op_a", a, data);
        check_value("rresp", 32'(OKAY), 32'(resp));
        read_reg(fp_pkg::REG_B, data, resp);
        check_value("op_b", b, data);
        check_value("rresp", 32'(OKAY), 32'(resp));
        finish_test("register_readback");

        for (int i = 0; i < 100; i++) begin
            a = random_operand();
            b = random_operand();
            // every fourth pair shares an exponent so cancellation shows up
            if (i % 4 == 0) begin
                b = {b[31], a[30:23], b[22:0]};
            end
            run_operation(fp_pkg::OP_ADD, a, b, data);
            check_value("result", expected_sum(a, b), data);
        end
        finish_test("random_add");

        for (int i = 0; i < 100; i++) begin
            a = random_operand();
            b = random_operand();
            run_operation(fp_pkg::OP_MUL, a, b, data);
            check_value("result", expected_product(a, b), data);
        end
        finish_test("random_mul");

        a = random_operand();
        b = a ^ 32'h8000_0000;
        write_reg(fp_pkg::REG_A, a, resp);
        write_reg(fp_pkg::REG_B, b, resp);
        write_reg(fp_pkg::REG_CTRL, 32'(fp_pkg::OP_ADD), resp);
        // second start lands while the add is still running
        write_reg(fp_pkg::REG_CTRL, 32'(fp_pkg::OP_MUL), resp);
        check_value("bresp", 32'(OKAY), 32'(resp));
        data = '0;
        while (!data[1]) read_reg(fp_pkg::REG_STATUS, data, resp);
        read_reg(fp_pkg::REG_RESULT, data, resp);
        check_value("result", 32'h0, data);
        repeat (8) step_cycle();
        read_reg(fp_pkg::REG_STATUS, data, resp);
        check_value("status", 32'h2, data);
        read_reg(fp_pkg::REG_RESULT, data, resp);
        check_value("result", 32'h0, data);
        finish_test("zero_result");

        write_reg(5'h14, 32'hdead_beef, resp);
        check_value("bresp", 32'(SLVERR), 32'(resp));
        read_reg(5'h14, data, resp);
        check_value("rresp", 32'(SLVERR), 32'(resp));
        check_value("rdata", 32'h0, data);
        read_reg(fp_pkg::REG_A, data, resp);
        check_value("op_a", a, data);
        finish_test("unmapped_offset");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+test
logic/fp_pkg.sv
logic/fp_op_if.sv
logic/fp_add.sv
logic/fp_mul.sv
logic/fp_axil_regs.sv
logic/fp_unit_top.sv
test/tb_fp_unit.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_unit -f all.f -o tb_fp_unit
./obj_dir/tb_fp_unit > sim.log
cat sim.log
if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
